/* source/histogram_defines.svh */
// Histogram engine widths and counts
// Shared by the package and every RTL block of the pixel histogram engine

`ifndef HISTOGRAM_DEFINES_SVH
`define HISTOGRAM_DEFINES_SVH

`define PIXEL_WIDTH      8      // bits per pixel
`define PIXELS_PER_WORD  16     // pixels in one input word
`define BUS_WIDTH        128    // SRAM data bus
`define ADDR_WIDTH       16     // SRAM address, top bit selects the bank

`define BIN_COUNT        256    // one bin per pixel value
`define COUNT_WIDTH      19     // enough for a 640x480 image in one bin
`define SLICE_WIDTH      5      // one word gives 0 to 16 hits per bin

`define BINS_PER_WORD    4      // count fields per scratch write
`define FIELD_WIDTH      32     // each count is zero-extended to this
`define BLOCK_COUNT      64     // scratch words per dump

// read address to accumulated word
`define PIPE_DEPTH       3

`endif

/* source/histogramPkg.sv */
// Histogram engine types
// Controller states and the packed bundles passed between the blocks

`include "histogram_defines.svh"

package histogramPkg;

    typedef enum logic [2:0]
    {
        stateIdle,
        stateScan,
        stateDrain,
        stateDump,
        stateHold
    } controlState_t;

    typedef struct packed
    {
        logic bank;     // selects the upper half of both SRAMs
        logic start;    // level, held by the host for the whole run
    } hostControl_t;

    typedef logic [`PIXELS_PER_WORD-1:0][`PIXEL_WIDTH-1:0] pixelWord_t;

    typedef struct packed
    {
        logic                                   valid;
        logic [`BIN_COUNT-1:0][`SLICE_WIDTH-1:0] count;   // hits per bin in one word
    } binSlice_t;

    typedef logic [`BINS_PER_WORD-1:0][`COUNT_WIDTH-1:0] countBlock_t;

    typedef struct packed
    {
        logic                   enable;
        logic [`ADDR_WIDTH-1:0] address;
        logic [`BUS_WIDTH-1:0]  data;
    } memWrite_t;

endpackage

/* source/histogramControl.sv */
// Histogram run sequencer
// Issues the image read addresses, waits out the pipeline, starts the dump
// and holds done until the host releases start

`timescale 1ns/1ns
`include "histogram_defines.svh"

module histogramControl
#(
    parameter logic [`ADDR_WIDTH-2:0]  ImageBase = '0,
    parameter logic [`COUNT_WIDTH-1:0] WordCount = 19'd10
)
(
    input  logic                        clock,
    input  logic                        reset,
    input  histogramPkg::hostControl_t  hostControl,
    input  logic                        dumpDone,
    output logic [`ADDR_WIDTH-1:0]      readAddress,
    output logic                        readStrobe,
    output logic                        clear,
    output logic                        dumpStart,
    output logic                        bank,
    output logic                        done
);
    import histogramPkg::*;

    controlState_t                      state;
    logic [`COUNT_WIDTH-1:0]            wordIndex;
    logic [`COUNT_WIDTH-1:0]            nextIndex;
    logic [$clog2(`PIPE_DEPTH)-1:0]     drainCount;

    assign nextIndex = wordIndex + 1'b1;

    // last drain cycle, the final word lands in the accumulators on this edge
    assign dumpStart = (state == stateDrain) && (drainCount == `PIPE_DEPTH - 1);

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state       <= stateIdle;
            wordIndex   <= '0;
            drainCount  <= '0;
            readAddress <= '0;
            readStrobe  <= 1'b0;
            clear       <= 1'b0;
            bank        <= 1'b0;
            done        <= 1'b0;
        end
        else
        begin
            clear <= 1'b0;
            case (state)
                stateIdle:
                begin
                    if (hostControl.start)
                    begin
                        state       <= stateScan;
                        bank        <= hostControl.bank;
                        clear       <= 1'b1;
                        wordIndex   <= '0;
                        readAddress <= {hostControl.bank, ImageBase};
                        readStrobe  <= 1'b1;
                    end
                end
                stateScan:
                begin
                    if (wordIndex == WordCount - 1'b1)
                    begin
                        state      <= stateDrain;
                        readStrobe <= 1'b0;   // last address stays on the bus
                        drainCount <= '0;
                    end
                    else
                    begin
                        wordIndex   <= nextIndex;
                        readAddress <= {bank, ImageBase} + `ADDR_WIDTH'(nextIndex);
                    end
                end
                stateDrain:
                begin
                    drainCount <= drainCount + 1'b1;
                    if (dumpStart)
                        state <= stateDump;
                end
                stateDump:
                begin
                    if (dumpDone)
                    begin
                        state <= stateHold;
                        done  <= 1'b1;
                    end
                end
                stateHold:
                begin
                    if (!hostControl.start)   // host has seen done
                    begin
                        state <= stateIdle;
                        done  <= 1'b0;
                    end
                end
                default: state <= stateIdle;
            endcase
        end
    end

endmodule

/* source/pixelBinCounter.sv */
// Pixel bin counter
// Captures one sixteen-pixel word, decodes every pixel one-hot and counts
// how many of the sixteen fall into each of the 256 bins

`timescale 1ns/1ns
`include "histogram_defines.svh"

module pixelBinCounter
(
    input  logic                     clock,
    input  logic                     reset,
    input  histogramPkg::pixelWord_t readData,
    input  logic                     readStrobe,
    output histogramPkg::binSlice_t  slice
);
    import histogramPkg::*;

    logic                                            strobeDelay;   // lines up with readData
    logic                                            wordValid;
    pixelWord_t                                      wordReg;
    logic [`PIXELS_PER_WORD-1:0][`BIN_COUNT-1:0]     decoded;
    logic [`BIN_COUNT-1:0][`SLICE_WIDTH-1:0]         binSum;

    function automatic logic [`BIN_COUNT-1:0] decodePixel(input logic [`PIXEL_WIDTH-1:0] value);
        return `BIN_COUNT'(1) << value;
    endfunction

    // balanced tree, each level one bit wider
    function automatic logic [`SLICE_WIDTH-1:0] sumSixteen(input logic [15:0] bits);
        logic [7:0][1:0] pairSum;
        logic [3:0][2:0] quadSum;
        logic [1:0][3:0] octSum;
        for (int k = 0; k < 8; k++)
            pairSum[k] = bits[2*k] + bits[2*k+1];
        for (int k = 0; k < 4; k++)
            quadSum[k] = pairSum[2*k] + pairSum[2*k+1];
        for (int k = 0; k < 2; k++)
            octSum[k] = quadSum[2*k] + quadSum[2*k+1];
        return octSum[0] + octSum[1];
    endfunction

    always_comb
    begin
        for (int p = 0; p < `PIXELS_PER_WORD; p++)
            decoded[p] = decodePixel(wordReg[p]);
    end

    always_comb
    begin
        logic [`PIXELS_PER_WORD-1:0] column;   // one decode bit from every pixel
        for (int b = 0; b < `BIN_COUNT; b++)
        begin
            for (int p = 0; p < `PIXELS_PER_WORD; p++)
                column[p] = decoded[p][b];
            binSum[b] = sumSixteen(column);
        end
    end

    always_ff @(posedge clock)
    begin
        if (strobeDelay)
            wordReg <= readData;
        slice.count <= binSum;
        if (reset)
        begin
            strobeDelay <= 1'b0;
            wordValid   <= 1'b0;
            slice.valid <= 1'b0;
        end
        else
        begin
            strobeDelay <= readStrobe;
            wordValid   <= strobeDelay;
            slice.valid <= wordValid;
        end
    end

endmodule

/* source/binAccumulator.sv */
// Bin accumulators
// Keeps a running count for each of the 256 pixel values and presents
// four neighbouring bins at a time for the dump

`timescale 1ns/1ns
`include "histogram_defines.svh"

module binAccumulator
(
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic                                 clear,
    input  histogramPkg::binSlice_t              slice,
    input  logic [$clog2(`BLOCK_COUNT)-1:0]      blockIndex,
    output histogramPkg::countBlock_t            countBlock
);

    logic [`BIN_COUNT-1:0][`COUNT_WIDTH-1:0] binCount;

    always_ff @(posedge clock)
    begin
        if (reset || clear)   // every run starts from zero
        begin
            binCount <= '0;
        end
        else if (slice.valid)
        begin
            for (int b = 0; b < `BIN_COUNT; b++)
                binCount[b] <= binCount[b] + `COUNT_WIDTH'(slice.count[b]);
        end
    end

    // block b holds bins 4b to 4b+3, lowest bin first
    always_comb
    begin
        for (int k = 0; k < `BINS_PER_WORD; k++)
            countBlock[k] = binCount[blockIndex * `BINS_PER_WORD + k];
    end

endmodule

/* source/countWriter.sv */
// Count writer
// Walks the 64 count blocks after dumpStart and writes one scratch word
// per cycle, four zero-extended counts each

`timescale 1ns/1ns
`include "histogram_defines.svh"

module countWriter
#(
    parameter logic [`ADDR_WIDTH-2:0] CountBase = '0
)
(
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               dumpStart,
    input  logic                               bank,
    input  histogramPkg::countBlock_t          countBlock,
    output logic [$clog2(`BLOCK_COUNT)-1:0]    blockIndex,
    output histogramPkg::memWrite_t            scratchWrite,
    output logic                               dumpDone
);

    logic                                          active;
    logic [`BINS_PER_WORD-1:0][`FIELD_WIDTH-1:0]   fields;

    always_comb
    begin
        for (int k = 0; k < `BINS_PER_WORD; k++)
            fields[k] = `FIELD_WIDTH'(countBlock[k]);
    end

    always_ff @(posedge clock)
    begin
        scratchWrite.address <= {bank, CountBase} + `ADDR_WIDTH'(blockIndex);
        scratchWrite.data    <= fields;
        if (reset)
        begin
            active              <= 1'b0;
            blockIndex          <= '0;
            scratchWrite.enable <= 1'b0;
            dumpDone            <= 1'b0;
        end
        else
        begin
            scratchWrite.enable <= active;
            dumpDone            <= active && (blockIndex == `BLOCK_COUNT - 1);  // with last write
            if (dumpStart)
            begin
                active     <= 1'b1;
                blockIndex <= '0;
            end
            else if (active)
            begin
                if (blockIndex == `BLOCK_COUNT - 1)
                    active <= 1'b0;
                blockIndex <= blockIndex + 1'b1;   // wraps back to zero
            end
        end
    end

endmodule

/* source/histogram.sv */
// Pixel histogram engine
// Reads an image from the input SRAM, counts every pixel value and
// dumps the 256 counts to the scratch SRAM

`timescale 1ns/1ns
`include "histogram_defines.svh"

module histogram
#(
    parameter logic [`ADDR_WIDTH-2:0]  ImageBase = '0,
    parameter logic [`ADDR_WIDTH-2:0]  CountBase = '0,
    parameter logic [`COUNT_WIDTH-1:0] WordCount = 19'd10
)
(
    input  logic                        clock,
    input  logic                        reset,
    input  histogramPkg::hostControl_t  hostControl,
    input  histogramPkg::pixelWord_t    readData,
    output logic [`ADDR_WIDTH-1:0]      readAddress,
    output histogramPkg::memWrite_t     scratchWrite,
    output logic                        done
);
    import histogramPkg::*;

    logic                               readStrobe;
    logic                               clear;
    logic                               dumpStart;
    logic                               dumpDone;
    logic                               bank;     // latched at start
    logic [$clog2(`BLOCK_COUNT)-1:0]    blockIndex;
    binSlice_t                          slice;
    countBlock_t                        countBlock;

    histogramControl #(.ImageBase(ImageBase), .WordCount(WordCount)) control_i
    (
        .clock(clock), .reset(reset), .hostControl(hostControl), .dumpDone(dumpDone),
        .readAddress(readAddress), .readStrobe(readStrobe), .clear(clear),
        .dumpStart(dumpStart), .bank(bank), .done(done)
    );

    pixelBinCounter counter_i
    (
        .clock(clock), .reset(reset), .readData(readData), .readStrobe(readStrobe),
        .slice(slice)
    );

    binAccumulator accumulator_i
    (
        .clock(clock), .reset(reset), .clear(clear), .slice(slice),
        .blockIndex(blockIndex), .countBlock(countBlock)
    );

    countWriter #(.CountBase(CountBase)) writer_i
    (
        .clock(clock), .reset(reset), .dumpStart(dumpStart), .bank(bank),
        .countBlock(countBlock), .blockIndex(blockIndex), .scratchWrite(scratchWrite),
        .dumpDone(dumpDone)
    );

endmodule

/* testbench/imageMemory.sv */
// Testbench SRAM model
// Holds both image banks, answers every read one cycle later and logs
// the scratch writes of one run

`timescale 1ns/1ns
`include "histogram_defines.svh"

module imageMemory
(
    input  logic                       clock,
    input  logic                       logClear,
    input  logic [`ADDR_WIDTH-1:0]     readAddress,
    output histogramPkg::pixelWord_t   readData,
    input  histogramPkg::memWrite_t    scratchWrite
);
    import histogramPkg::*;

    pixelWord_t storage [0:(1 << `ADDR_WIDTH) - 1];   // both banks
    memWrite_t  writeLog [0:`BLOCK_COUNT-1];
    int         writeCount;

    // loaded by the testbench between runs
    task automatic loadWord(input logic [`ADDR_WIDTH-1:0] address, input pixelWord_t word);
        storage[address] = word;
    endtask

    always_ff @(posedge clock)
    begin
        readData <= storage[readAddress];   // reads every cycle
    end

    always_ff @(posedge clock)
    begin
        if (logClear)
        begin
            writeCount <= 0;
        end
        else if (scratchWrite.enable)
        begin
            if (writeCount < `BLOCK_COUNT)   // extra writes are only counted
                writeLog[writeCount] <= scratchWrite;
            writeCount <= writeCount + 1;
        end
    end

endmodule

/* testbench/histogramTb.sv */
// Histogram engine testbench
// Applies a table of image runs and checks every scratch write against
// a reference histogram built from the same pixels

`timescale 1ns/1ns
`include "histogram_defines.svh"

module histogramTb;
    import histogramPkg::*;

    localparam logic [`ADDR_WIDTH-2:0]  ImageBase = 15'h0120;
    localparam logic [`ADDR_WIDTH-2:0]  CountBase = 15'h0400;
    localparam logic [`COUNT_WIDTH-1:0] WordCount = 19'd10;
    localparam int RowCount = 6;
    localparam int WatchdogCycles =
        2 * RowCount * (WordCount + `PIPE_DEPTH + `BLOCK_COUNT + 20);

    typedef enum logic [1:0]
    {
        fillConstant,
        fillRamp,
        fillRandom
    } fillMode_t;

    typedef struct packed
    {
        logic       bank;
        fillMode_t  mode;
        logic [7:0] value;   // constant pixel or ramp start
    } runRow_t;

    logic                   clock;
    logic                   reset;
    logic                   logClear;
    hostControl_t           hostControl;
    pixelWord_t             readData;
    logic [`ADDR_WIDTH-1:0] readAddress;
    memWrite_t              scratchWrite;
    logic                   done;

    runRow_t     runTable [0:RowCount-1];
    int          expectedHist [0:`BIN_COUNT-1];
    logic [31:0] lfsrState;

    histogram #(.ImageBase(ImageBase), .CountBase(CountBase), .WordCount(WordCount)) dut_i
    (
        .clock(clock), .reset(reset), .hostControl(hostControl), .readData(readData),
        .readAddress(readAddress), .scratchWrite(scratchWrite), .done(done)
    );

    imageMemory mem_i
    (
        .clock(clock), .logClear(logClear), .readAddress(readAddress),
        .readData(readData), .scratchWrite(scratchWrite)
    );

    always #10 clock = ~clock;

    task automatic stopOnFailure();
        $display("Simulation FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic checkDone(input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("Error at %0t ns: done expected %b, got %b", $time, expected, actual);
            stopOnFailure();
        end
    endtask

    task automatic checkEnable(input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("Error at %0t ns: scratchWrite.enable expected %b, got %b",
                     $time, expected, actual);
            stopOnFailure();
        end
    endtask

    task automatic checkWriteCount(input int actual, input int expected);
        if (actual != expected)
        begin
            $display("Error at %0t ns: write count expected %0d, got %0d",
                     $time, expected, actual);
            stopOnFailure();
        end
    endtask

    // logged writes always carry enable, so only address and data are compared
    task automatic checkWrite(input int index, input memWrite_t actual, input memWrite_t expected);
        if (actual.address !== expected.address)
        begin
            $display("Error at %0t ns: scratchWrite.address of write %0d expected %h, got %h",
                     $time, index, expected.address, actual.address);
            stopOnFailure();
        end
        if (actual.data !== expected.data)
        begin
            $display("Error at %0t ns: scratchWrite.data of write %0d expected %h, got %h",
                     $time, index, expected.data, actual.data);
            stopOnFailure();
        end
    endtask

    // Galois form, shifts right
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
    endfunction

    function automatic logic [7:0] randomPixel();
        logic [7:0] pixel;
        pixel = '0;
        for (int i = 0; i < 8; i++)
        begin
            lfsrState = lfsrStep(lfsrState);   // one step per bit
            pixel = {pixel[6:0], lfsrState[0]};
        end
        return pixel;
    endfunction

    // unselected bank gets data that would spoil the counts if read
    function automatic pixelWord_t otherBankWord(input logic [`ADDR_WIDTH-1:0] address);
        pixelWord_t word;
        for (int p = 0; p < `PIXELS_PER_WORD; p++)
            word[p] = (address[15:8] ^ address[7:0]) + 8'(p * 29) + 8'd3;
        return word;
    endfunction

    task automatic fillImages(input runRow_t row);
        logic [`ADDR_WIDTH-1:0] base;
        logic [`ADDR_WIDTH-1:0] other;
        pixelWord_t             word;
        base  = {row.bank, ImageBase};
        other = {~row.bank, ImageBase};
        for (int b = 0; b < `BIN_COUNT; b++)
            expectedHist[b] = 0;
        for (int w = 0; w < WordCount; w++)
        begin
            for (int p = 0; p < `PIXELS_PER_WORD; p++)
            begin
                case (row.mode)
                    fillConstant: word[p] = row.value;
                    fillRamp:     word[p] = row.value + 8'(w * 16 + p);
                    default:      word[p] = randomPixel();
                endcase
                expectedHist[word[p]] = expectedHist[word[p]] + 1;
            end
            mem_i.loadWord(base + 16'(w), word);
            mem_i.loadWord(other + 16'(w), otherBankWord(other + 16'(w)));
        end
    endtask

    task automatic checkDump(input logic bank);
        memWrite_t expected;
        for (int i = 0; i < `BLOCK_COUNT; i++)
        begin
            expected         = '0;
            expected.address = {bank, CountBase} + 16'(i);
            for (int k = 0; k < `BINS_PER_WORD; k++)   // lowest bin in the low field
                expected.data[k*`FIELD_WIDTH +: `FIELD_WIDTH] = 32'(expectedHist[4*i + k]);
            checkWrite(i, mem_i.writeLog[i], expected);
        end
    endtask

    task automatic checkReadAddress(input logic bank);
        logic [`ADDR_WIDTH-1:0] first;
        first = {bank, ImageBase};
        if (readAddress < first || readAddress >= first + 16'(WordCount))
        begin
            $display("Read address %h at %0t ns is outside the image region of bank %0d",
                     readAddress, $time, bank);
            stopOnFailure();
        end
    endtask

    task automatic runOne(input runRow_t row);
        fillImages(row);
        @(posedge clock);
        hostControl <= {row.bank, 1'b1};
        logClear    <= 1'b1;
        @(posedge clock);
        logClear    <= 1'b0;
        do
        begin
            @(negedge clock);
            checkReadAddress(row.bank);
        end
        while (done !== 1'b1);
        checkWriteCount(mem_i.writeCount, `BLOCK_COUNT);   // done only after the last write
        checkDump(row.bank);
        repeat (3)
        begin
            @(negedge clock);
            checkDone(done, 1'b1);
        end
        @(posedge clock);
        hostControl <= {row.bank, 1'b0};
        @(posedge clock);
        @(negedge clock);
        checkDone(done, 1'b0);
        checkWriteCount(mem_i.writeCount, `BLOCK_COUNT);
    endtask

    initial
    begin
        clock       = 1'b0;
        reset       = 1'b1;
        logClear    = 1'b1;
        hostControl = '0;
        lfsrState   = 32'h3ba37461;
        runTable[0] = {1'b0, fillConstant, 8'h5a};
        runTable[1] = {1'b1, fillConstant, 8'h00};   // must not carry bin 5a over
        runTable[2] = {1'b0, fillRamp, 8'h10};
        runTable[3] = {1'b1, fillRandom, 8'h00};
        runTable[4] = {1'b0, fillRandom, 8'h00};
        runTable[5] = {1'b1, fillConstant, 8'hff};
        repeat (2) @(posedge clock);
        reset    <= 1'b0;
        logClear <= 1'b0;
        repeat (5)
        begin
            @(negedge clock);
            checkDone(done, 1'b0);
            checkEnable(scratchWrite.enable, 1'b0);
        end
        checkWriteCount(mem_i.writeCount, 0);
        for (int r = 0; r < RowCount; r++)
            runOne(runTable[r]);
        $display("Simulation PASSED");
        $finish;
    end

    initial
    begin
        repeat (WatchdogCycles) @(posedge clock);
        $display("Timeout after %0d cycles, the engine never finished and the run hung",
                 WatchdogCycles);
        stopOnFailure();
    end

endmodule

/* sim.f */
+incdir+source
source/histogramPkg.sv
source/histogramControl.sv
source/pixelBinCounter.sv
source/binAccumulator.sv
source/countWriter.sv
source/histogram.sv
testbench/imageMemory.sv
testbench/histogramTb.sv
